// File: mem_pkg.sv
package mem_pkg;

   localparam int MEM_BYTES = 128;
   localparam int MEM_AW    = 7;    // log2 of MEM_BYTES
   localparam int BYTE_W    = 8;

   // one storage cell, one byte lane wide
   typedef logic [BYTE_W-1:0] mem_byte_t;

endpackage

// File: axi_pkg.sv
package axi_pkg;
   import mem_pkg::*;

   localparam int ID_W     = 4;
   localparam int ADDR_W   = 32;
   localparam int DATA_W   = 32;
   localparam int STRB_W   = DATA_W / 8;
   localparam int LEN_W    = 4;     // beats = len + 1
   localparam int SIZE_W   = 3;     // bytes per beat = 2**size
   localparam int MAX_SIZE = 2;     // widest beat is the full 4-byte bus

   typedef enum logic [1:0] {
      FIXED = 2'b00,
      INCR  = 2'b01,
      WRAP  = 2'b10
   } burst_t;

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } resp_t;

   // shared by aw and ar
   typedef struct packed {
      logic [ID_W-1:0]   id;
      logic [ADDR_W-1:0] addr;
      logic [LEN_W-1:0]  len;
      logic [SIZE_W-1:0] size;
      burst_t            burst;
   } ax_req_t;

   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic [STRB_W-1:0] strb;
      logic              last;
   } w_beat_t;

   typedef struct packed {
      logic [ID_W-1:0] id;
      resp_t           resp;
   } b_resp_t;

   typedef struct packed {
      logic [ID_W-1:0]   id;
      logic [DATA_W-1:0] data;
      resp_t             resp;
      logic              last;
   } r_beat_t;

   // size checked first, then the start address, then the wrap length
   function automatic resp_t check_req(input ax_req_t req);
      resp_t resp;
      resp = OKAY;
      if (req.size > SIZE_W'(MAX_SIZE))
         resp = SLVERR;
      else if (req.addr >= ADDR_W'(MEM_BYTES))
         resp = DECERR;
      else if (req.burst == WRAP && !(req.len inside {1, 3, 7, 15}))
         resp = SLVERR;   // wrap needs 2, 4, 8 or 16 beats
      return resp;
   endfunction

endpackage

// File: burst_addr_gen.sv
`timescale 1ns/1ns

module burst_addr_gen
   import axi_pkg::*;
(
   input  logic              clk,
   input  logic              resetn,
   input  logic              load,
   input  logic              step,
   input  ax_req_t           req,
   output logic [ADDR_W-1:0] addr,
   output logic              last
);

   logic [ADDR_W-1:0] beat_bytes_q;
   logic [ADDR_W-1:0] wrap_mask_q;   // window size minus one
   burst_t            burst_q;
   logic [LEN_W-1:0]  remain_q;      // beats still to come after this one
   logic [ADDR_W-1:0] incr_addr;
   logic [ADDR_W-1:0] next_addr;

   assign incr_addr = addr + beat_bytes_q;

   always_comb begin
      case (burst_q)
         FIXED: begin
            next_addr = addr;
         end
         WRAP: begin
            // keep the window base, let the offset roll over inside it
            next_addr = (addr & ~wrap_mask_q) | (incr_addr & wrap_mask_q);
         end
         default: begin
            next_addr = incr_addr;
         end
      endcase
   end

   always_ff @(posedge clk or negedge resetn) begin
      if (!resetn) begin
         addr         <= '0;
         beat_bytes_q <= '0;
         wrap_mask_q  <= '0;
         burst_q      <= FIXED;
         remain_q     <= '0;
      end else if (load) begin
         addr         <= req.addr;
         beat_bytes_q <= ADDR_W'(1) << req.size;
         wrap_mask_q  <= ((ADDR_W'(req.len) + ADDR_W'(1)) << req.size) - ADDR_W'(1);
         burst_q      <= req.burst;
         remain_q     <= req.len;
      end else if (step && remain_q != '0) begin
         addr     <= next_addr;
         remain_q <= remain_q - 1'b1;
      end
   end

   assign last = (remain_q == '0);

endmodule

// File: byte_mem.sv
`timescale 1ns/1ns

module byte_mem
   import axi_pkg::*, mem_pkg::*;
(
   input  logic              clk,
   input  logic              wr_en,
   input  logic [MEM_AW:0]   wr_addr,   // msb set means out of range
   input  logic [DATA_W-1:0] wr_data,
   input  logic [STRB_W-1:0] wr_strb,
   input  logic [ADDR_W-1:0] rd_addr,
   output logic [DATA_W-1:0] rd_data
);

   mem_byte_t mem [MEM_BYTES] = '{default: '0};

   // per-lane byte addresses, one spare bit so a carry can't alias low
   logic [MEM_AW+1:0] wr_lane [STRB_W];
   logic [ADDR_W:0]   rd_lane [STRB_W];

   always_comb begin
      for (int k = 0; k < STRB_W; k++) begin
         wr_lane[k] = {1'b0, wr_addr} + (MEM_AW + 2)'(k);
         rd_lane[k] = {1'b0, rd_addr} + (ADDR_W + 1)'(k);
         if (rd_lane[k] < MEM_BYTES)
            rd_data[BYTE_W*k +: BYTE_W] = mem[rd_lane[k][MEM_AW-1:0]];
         else
            rd_data[BYTE_W*k +: BYTE_W] = '0;   // past the end reads zero
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         for (int k = 0; k < STRB_W; k++) begin
            if (wr_strb[k] && wr_lane[k] < MEM_BYTES)
               mem[wr_lane[k][MEM_AW-1:0]] <= wr_data[BYTE_W*k +: BYTE_W];
         end
      end
   end

endmodule

// File: write_ctrl.sv
`timescale 1ns/1ns

module write_ctrl
   import axi_pkg::*;
(
   input  logic              clk,
   input  logic              resetn,
   // write address
   input  logic              aw_valid,
   output logic              aw_ready,
   input  ax_req_t           aw,
   // write data
   input  logic              w_valid,
   output logic              w_ready,
   input  w_beat_t           w,
   // write response
   output logic              b_valid,
   input  logic              b_ready,
   output b_resp_t           b,
   // address generator
   output logic              gen_load,
   output logic              gen_step,
   output ax_req_t           gen_req,
   // memory write port
   output logic              mem_wr_en,
   output logic [DATA_W-1:0] mem_wr_data,
   output logic [STRB_W-1:0] mem_wr_strb
);

   typedef enum logic [1:0] {
      IDLE,
      DATA,
      RESP
   } state_t;

   state_t          state;
   state_t          state_d;
   logic [ID_W-1:0] id_q;
   resp_t           resp_q;
   logic            aw_hs;
   logic            w_hs;

   assign aw_ready = (state == IDLE);
   assign w_ready  = (state == DATA);
   assign b_valid  = (state == RESP);

   assign aw_hs = aw_valid && aw_ready;
   assign w_hs  = w_valid && w_ready;

   // generator latches the request on the aw handshake
   assign gen_load = aw_hs;
   assign gen_req  = aw;
   assign gen_step = w_hs;   // advance after every accepted beat

   assign mem_wr_en   = w_hs;
   assign mem_wr_data = w.data;
   assign mem_wr_strb = (resp_q == OKAY) ? w.strb : '0;   // bad burst, beats sink

   assign b = '{id: id_q, resp: resp_q};

   always_comb begin
      state_d = state;
      case (state)
         IDLE: begin
            if (aw_hs)
               state_d = DATA;
         end
         DATA: begin
            if (w_hs && w.last)
               state_d = RESP;
         end
         RESP: begin
            if (b_ready)
               state_d = IDLE;
         end
         default: begin
            state_d = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or negedge resetn) begin
      if (!resetn) begin
         state  <= IDLE;
         id_q   <= '0;
         resp_q <= OKAY;
      end else begin
         state <= state_d;
         if (aw_hs) begin
            id_q   <= aw.id;
            resp_q <= check_req(aw);
         end
      end
   end

endmodule

// File: read_ctrl.sv
`timescale 1ns/1ns

module read_ctrl
   import axi_pkg::*;
(
   input  logic              clk,
   input  logic              resetn,
   // read address
   input  logic              ar_valid,
   output logic              ar_ready,
   input  ax_req_t           ar,
   // read data
   output logic              r_valid,
   input  logic              r_ready,
   output r_beat_t           r,
   // address generator
   output logic              gen_load,
   output logic              gen_step,
   output ax_req_t           gen_req,
   input  logic              gen_last,
   // memory read port, valid for the current beat address
   input  logic [DATA_W-1:0] mem_rd_data
);

   typedef enum logic {
      IDLE,
      BEAT
   } state_t;

   state_t            state;
   state_t            state_d;
   logic [ID_W-1:0]   id_q;
   resp_t             resp_q;
   logic              ar_hs;
   logic              r_hs;
   logic [DATA_W-1:0] beat_data;

   assign ar_ready = (state == IDLE);
   assign r_valid  = (state == BEAT);

   assign ar_hs = ar_valid && ar_ready;
   assign r_hs  = r_valid && r_ready;

   assign gen_load = ar_hs;
   assign gen_req  = ar;
   // next beat address settles right after the handshake, so no bubble
   assign gen_step = r_hs;

   // error bursts still run their full length, just with zero data
   assign beat_data = (resp_q == OKAY) ? mem_rd_data : '0;

   assign r = '{id: id_q, data: beat_data, resp: resp_q, last: gen_last};

   always_comb begin
      state_d = state;
      case (state)
         IDLE: begin
            if (ar_hs)
               state_d = BEAT;
         end
         BEAT: begin
            if (r_hs && gen_last)
               state_d = IDLE;
         end
         default: begin
            state_d = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or negedge resetn) begin
      if (!resetn) begin
         state  <= IDLE;
         id_q   <= '0;
         resp_q <= OKAY;
      end else begin
         state <= state_d;
         if (ar_hs) begin
            id_q   <= ar.id;
            resp_q <= check_req(ar);
         end
      end
   end

endmodule

// File: axi_mem_slave.sv
`timescale 1ns/1ns

module axi_mem_slave
   import axi_pkg::*, mem_pkg::*;
(
   input  logic    clk,
   input  logic    resetn,
   input  logic    aw_valid,
   output logic    aw_ready,
   input  ax_req_t aw,
   input  logic    w_valid,
   output logic    w_ready,
   input  w_beat_t w,
   output logic    b_valid,
   input  logic    b_ready,
   output b_resp_t b,
   input  logic    ar_valid,
   output logic    ar_ready,
   input  ax_req_t ar,
   output logic    r_valid,
   input  logic    r_ready,
   output r_beat_t r
);

   logic              wr_gen_load;
   logic              wr_gen_step;
   ax_req_t           wr_gen_req;
   logic [ADDR_W-1:0] wr_addr;
   logic [MEM_AW:0]   mem_wr_addr;
   logic              mem_wr_en;
   logic [DATA_W-1:0] mem_wr_data;
   logic [STRB_W-1:0] mem_wr_strb;

   logic              rd_gen_load;
   logic              rd_gen_step;
   ax_req_t           rd_gen_req;
   logic [ADDR_W-1:0] rd_addr;
   logic              rd_last;
   logic [DATA_W-1:0] mem_rd_data;

   // any upper address bit set folds into the out-of-range flag
   assign mem_wr_addr = {|wr_addr[ADDR_W-1:MEM_AW], wr_addr[MEM_AW-1:0]};

   write_ctrl u_write_ctrl (
      .clk         (clk),
      .resetn      (resetn),
      .aw_valid    (aw_valid),
      .aw_ready    (aw_ready),
      .aw          (aw),
      .w_valid     (w_valid),
      .w_ready     (w_ready),
      .w           (w),
      .b_valid     (b_valid),
      .b_ready     (b_ready),
      .b           (b),
      .gen_load    (wr_gen_load),
      .gen_step    (wr_gen_step),
      .gen_req     (wr_gen_req),
      .mem_wr_en   (mem_wr_en),
      .mem_wr_data (mem_wr_data),
      .mem_wr_strb (mem_wr_strb)
   );

   // write side ends on w.last, so the generator's last goes unused
   burst_addr_gen u_wr_gen (
      .clk    (clk),
      .resetn (resetn),
      .load   (wr_gen_load),
      .step   (wr_gen_step),
      .req    (wr_gen_req),
      .addr   (wr_addr),
      .last   ()
   );

   read_ctrl u_read_ctrl (
      .clk         (clk),
      .resetn      (resetn),
      .ar_valid    (ar_valid),
      .ar_ready    (ar_ready),
      .ar          (ar),
      .r_valid     (r_valid),
      .r_ready     (r_ready),
      .r           (r),
      .gen_load    (rd_gen_load),
      .gen_step    (rd_gen_step),
      .gen_req     (rd_gen_req),
      .gen_last    (rd_last),
      .mem_rd_data (mem_rd_data)
   );

   burst_addr_gen u_rd_gen (
      .clk    (clk),
      .resetn (resetn),
      .load   (rd_gen_load),
      .step   (rd_gen_step),
      .req    (rd_gen_req),
      .addr   (rd_addr),
      .last   (rd_last)
   );

   byte_mem u_byte_mem (
      .clk     (clk),
      .wr_en   (mem_wr_en),
      .wr_addr (mem_wr_addr),
      .wr_data (mem_wr_data),
      .wr_strb (mem_wr_strb),
      .rd_addr (rd_addr),
      .rd_data (mem_rd_data)
   );

endmodule

// File: tb_axi_model.svh
// reference model and random source, shared by the testbench tasks
logic [15:0] lfsr_q = 16'd9;
logic [7:0]  ref_mem [128] = '{default: '0};

// x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
   logic [31:0] v;
   logic        fb;
   v = '0;
   for (int i = 0; i < n; i++) begin
      fb    = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      v     = {v[30:0], fb};
   end
   return v;
endfunction

function automatic resp_t model_resp(input ax_req_t req);
   if (req.size > 3'd2)
      return SLVERR;
   if (req.addr >= 32'd128)
      return DECERR;
   if (req.burst == WRAP && req.len != 1 && req.len != 3 && req.len != 7 && req.len != 15)
      return SLVERR;
   return OKAY;
endfunction

function automatic logic [31:0] next_beat(input ax_req_t req, input logic [31:0] addr);
   logic [31:0] bytes;
   logic [31:0] window;
   logic [31:0] base;
   bytes  = 32'd1 << req.size;
   window = bytes * (req.len + 1);
   base   = addr - (addr % window);   // aligned wrap window
   case (req.burst)
      FIXED:   return addr;
      WRAP:    return base + ((addr + bytes - base) % window);
      default: return addr + bytes;
   endcase
endfunction

function automatic void model_write(input logic [31:0] addr, input logic [31:0] data,
                                    input logic [3:0] strb);
   for (int k = 0; k < 4; k++) begin
      if (strb[k] && addr + k < 128)
         ref_mem[addr + k] = data[8*k +: 8];
   end
endfunction

function automatic logic [31:0] model_read(input logic [31:0] addr);
   logic [31:0] word;
   word = '0;
   for (int k = 0; k < 4; k++) begin
      if (addr + k < 128)
         word[8*k +: 8] = ref_mem[addr + k];
   end
   return word;
endfunction

// File: tb_axi_mem.sv
`timescale 1ns/1ns

module tb_axi_mem
   import axi_pkg::*;
();

   localparam int TIMEOUT = 100;   // cycles per handshake wait

   logic    clk = 1'b0;
   logic    resetn;
   logic    aw_valid;
   logic    aw_ready;
   ax_req_t aw;
   logic    w_valid;
   logic    w_ready;
   w_beat_t w;
   logic    b_valid;
   logic    b_ready;
   b_resp_t b;
   logic    ar_valid;
   logic    ar_ready;
   ax_req_t ar;
   logic    r_valid;
   logic    r_ready;
   r_beat_t r;

   string chan_name [5] = '{"aw_ready", "w_ready", "b_valid/b", "ar_ready", "r_valid/r"};

   `include "tb_axi_model.svh"

   axi_mem_slave u_axi_mem_slave (.*);

   always #4 clk = ~clk;

   task automatic abort_run();
      $display("*** TEST FAILED ***");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_val(input string name, input logic [63:0] act, input logic [63:0] exp);
      if (act !== exp) begin
         $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, act, exp);
         abort_run();
      end
   endtask

   function automatic logic chan_flag(input int ch);
      case (ch)
         0:       return aw_ready;
         1:       return w_ready;
         2:       return b_valid;
         3:       return ar_ready;
         default: return r_valid;
      endcase
   endfunction

   // valid together with its payload
   function automatic logic [63:0] payload(input int ch);
      if (ch == 2)
         return {b_valid, b};
      return {r_valid, r};
   endfunction

   task automatic wait_flag(input int ch);
      int n;
      n = 0;
      @(negedge clk);
      while (!chan_flag(ch)) begin
         n++;
         if (n > TIMEOUT) begin
            $display("timeout: %s never came up, the channel did not respond", chan_name[ch]);
            abort_run();
         end
         @(negedge clk);
      end
   endtask

   // random back-pressure, payload must hold, then one ready cycle
   task automatic stall_accept(input int ch);
      logic [63:0] held;
      int          stall;
      held  = payload(ch);
      stall = rand_bits(2);
      repeat (stall) begin
         @(negedge clk);
         check_val(chan_name[ch], payload(ch), held);
      end
      @(posedge clk);
      b_ready <= (ch == 2);
      r_ready <= (ch == 4);
      @(negedge clk);
      check_val(chan_name[ch], payload(ch), held);
      @(posedge clk);   // handshake edge
      b_ready <= 1'b0;
      r_ready <= 1'b0;
   endtask

   task automatic do_write(input ax_req_t req);
      resp_t       exp_resp;
      logic [31:0] addr;
      logic [31:0] data;
      logic [3:0]  strb;
      exp_resp = model_resp(req);
      addr     = req.addr;
      @(posedge clk);
      aw_valid <= 1'b1;
      aw       <= req;
      wait_flag(0);
      for (int i = 0; i <= req.len; i++) begin
         data = rand_bits(32);
         strb = 4'(rand_bits(4));
         @(posedge clk);
         aw_valid <= 1'b0;
         w_valid  <= 1'b1;
         w        <= '{data: data, strb: strb, last: (i == req.len)};
         wait_flag(1);
         if (exp_resp == OKAY)
            model_write(addr, data, strb);
         addr = next_beat(req, addr);
      end
      @(posedge clk);
      w_valid <= 1'b0;
      wait_flag(2);
      check_val("b", b, {req.id, exp_resp});
      stall_accept(2);
   endtask

   task automatic do_read(input ax_req_t req);
      resp_t       exp_resp;
      logic [31:0] addr;
      r_beat_t     exp;
      exp_resp = model_resp(req);
      addr     = req.addr;
      @(posedge clk);
      ar_valid <= 1'b1;
      ar       <= req;
      wait_flag(3);
      @(posedge clk);
      ar_valid <= 1'b0;
      for (int i = 0; i <= req.len; i++) begin
         exp.id   = req.id;
         exp.data = (exp_resp == OKAY) ? model_read(addr) : '0;
         exp.resp = exp_resp;
         exp.last = (i == req.len);
         wait_flag(4);
         check_val("r", r, exp);
         stall_accept(4);
         addr = next_beat(req, addr);
      end
      @(negedge clk);
      check_val("r_valid", r_valid, 1'b0);   // burst closed, no extra beat
      check_val("ar_ready", ar_ready, 1'b1);
   endtask

   task automatic write_read(input logic [31:0] addr, input logic [3:0] len,
                             input logic [2:0] size, input burst_t burst);
      ax_req_t req;
      req = '{id: 4'(rand_bits(4)), addr: addr, len: len, size: size, burst: burst};
      do_write(req);
      req.id = 4'(rand_bits(4));
      do_read(req);
   endtask

   initial begin
      logic [2:0] size;
      ax_req_t    req;
      resetn   = 1'b0;
      aw_valid = 1'b0;
      aw       = '0;
      w_valid  = 1'b0;
      w        = '0;
      b_ready  = 1'b0;
      ar_valid = 1'b0;
      ar       = '0;
      r_ready  = 1'b0;
      repeat (2) @(posedge clk);
      resetn <= 1'b1;
      @(negedge clk);
      check_val("{aw_ready,ar_ready,b_valid,r_valid,w_ready}",
                {aw_ready, ar_ready, b_valid, r_valid, w_ready}, 5'b11000);

      for (int n = 0; n < 12; n++) begin
         size = 3'(rand_bits(2));
         if (size == 3'd3)
            size = 3'd2;
         write_read(rand_bits(7), 4'(rand_bits(4)), size, INCR);
      end
      for (int n = 0; n < 4; n++)
         write_read(rand_bits(7), 4'(rand_bits(4)), 3'd2, FIXED);
      // 2, 4, 8 and 16 beats from an odd start
      for (int n = 0; n < 4; n++)
         write_read(rand_bits(7) | 32'd1, 4'((2 << n) - 1), 3'd2, WRAP);
      write_read(rand_bits(7), 4'd2, 3'd2, WRAP);   // 3 beats
      write_read(rand_bits(7), 4'(rand_bits(4)), 3'd3, INCR);
      write_read(32'd128 + rand_bits(20), 4'(rand_bits(4)), 3'd2, INCR);

      // whole memory against the model
      for (int n = 0; n < 2; n++) begin
         req = '{id: 4'(rand_bits(4)), addr: 64 * n, len: 4'd15, size: 3'd2, burst: INCR};
         do_read(req);
      end
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

// File: tb.f
+incdir+.
mem_pkg.sv
axi_pkg.sv
burst_addr_gen.sv
byte_mem.sv
write_ctrl.sv
read_ctrl.sv
axi_mem_slave.sv
tb_axi_mem.sv
